// File: logic/rp_pkg.sv
// Shared widths, sample types and constants of the analog signal path
// Register map and identification word of the control block

package rp_pkg;

  ////////////////////////////////////////
  // Analog channels
  ////////////////////////////////////////

  // Two ADC inputs, two DAC outputs
  localparam int unsigned RP_CHN    = 2;
  // Raw converter word, lowest 2 bits unused by the 14-bit ADC
  localparam int unsigned ADC_RAW_W = 16;
  localparam int unsigned SMP_W     = 14;

  typedef logic        [ADC_RAW_W-1:0] adc_raw_t;
  // Two's complement sample inside the design
  typedef logic signed [SMP_W-1:0]     smp_t;
  // Offset code toward the DAC pins
  typedef logic        [SMP_W-1:0]     dac_code_t;

  ////////////////////////////////////////
  // PDM outputs
  ////////////////////////////////////////

  localparam int unsigned PDM_CHN = 4;
  localparam int unsigned PDM_W   = 8;
  // Accumulator modulus, full scale level gives a constant high
  localparam int unsigned PDM_RNG = 255;

  typedef logic [PDM_W-1:0] pdm_lvl_t;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam int unsigned REG_AW = 4;
  localparam int unsigned REG_DW = 32;

  // Read-only identification word
  localparam logic [REG_AW-1:0] REG_ID   = 4'd0;
  // Loopback select, bit i for channel i
  localparam logic [REG_AW-1:0] REG_LOOP = 4'd1;
  // First of four PDM level registers, bits 7:0
  localparam logic [REG_AW-1:0] REG_PDM0 = 4'd4;

  localparam logic [REG_DW-1:0] RP_ID_VAL = 32'h5250_0a14;

endpackage

// File: logic/reg_bus_if.sv
// Register access bus between the pins and the control registers
// Single-cycle write and read strobes, no acknowledge

`timescale 1ns/1ps

interface reg_bus_if;

  import rp_pkg::*;

  // Strobes, one cycle each
  logic              wen;
  logic              ren;
  // Word address shared by writes and reads
  logic [REG_AW-1:0] addr;
  logic [REG_DW-1:0] wdata;
  // Read data, valid the cycle after ren and held
  logic [REG_DW-1:0] rdata;

  // Pin side
  modport master (
    output wen,
    output ren,
    output addr,
    output wdata,
    input  rdata
  );

  // Register block side
  modport slave (
    input  wen,
    input  ren,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// File: logic/rp_ctl_regs.sv
// Control register block
// Identification word, loopback select bits, PDM levels
// Registered read data over the register bus

`timescale 1ns/1ps

module rp_ctl_regs (
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  reg_bus_if.slave                                  bus,
  output logic               [rp_pkg::RP_CHN-1:0]   loop_o,
  output rp_pkg::pdm_lvl_t   [rp_pkg::PDM_CHN-1:0]  pdm_lvl_o
);

  import rp_pkg::*;

  logic     [RP_CHN-1:0]  loop_q;
  pdm_lvl_t [PDM_CHN-1:0] lvl_q;
  // Read data before the output flop
  logic     [REG_DW-1:0]  rd_mux;

  ////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      loop_q <= '0;
      lvl_q  <= '0;
    end else if (bus.wen) begin
      // Loopback bits, one per channel
      if (bus.addr == REG_LOOP) begin
        loop_q <= bus.wdata[RP_CHN-1:0];
      end
      // PDM levels at consecutive addresses
      for (int i = 0; i < PDM_CHN; i++) begin
        if (bus.addr == REG_PDM0 + REG_AW'(i)) begin
          lvl_q[i] <= bus.wdata[PDM_W-1:0];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read multiplexer
  ////////////////////////////////////////

  always_comb begin
    // Unmapped addresses read as zero
    rd_mux = '0;
    if (bus.addr == REG_ID) begin
      rd_mux = RP_ID_VAL;
    end
    if (bus.addr == REG_LOOP) begin
      rd_mux[RP_CHN-1:0] = loop_q;
    end
    for (int i = 0; i < PDM_CHN; i++) begin
      if (bus.addr == REG_PDM0 + REG_AW'(i)) begin
        rd_mux[PDM_W-1:0] = lvl_q[i];
      end
    end
  end

  // Captured on the read strobe, held until the next read
  // Shows contents from before a write at the same edge
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      bus.rdata <= '0;
    end else if (bus.ren) begin
      bus.rdata <= rd_mux;
    end
  end

  // Configuration toward the signal path
  assign loop_o    = loop_q;
  assign pdm_lvl_o = lvl_q;

endmodule

// File: logic/adc_frontend.sv
// ADC front end for both channels
// Format conversion to signed samples and digital loopback select

`timescale 1ns/1ps

module adc_frontend (
  input  logic                                   adc_clk,
  input  logic                                   top_rst,
  input  rp_pkg::adc_raw_t [rp_pkg::RP_CHN-1:0]  adc_dat_i,
  input  rp_pkg::smp_t     [rp_pkg::RP_CHN-1:0]  gen_dat_i,
  input  logic             [rp_pkg::RP_CHN-1:0]  loop_i,
  output rp_pkg::smp_t     [rp_pkg::RP_CHN-1:0]  adc_smp_o
);

  import rp_pkg::*;

  // Converted ADC words
  smp_t [RP_CHN-1:0] adc_cnv;
  // After the loopback multiplexer
  smp_t [RP_CHN-1:0] smp_sel;

  ////////////////////////////////////////
  // Conversion and loopback
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < RP_CHN; i++) begin
      // Converter has an inverted slope, sign bit stays
      // Two low bits are unused by the 14-bit part
      adc_cnv[i] = {adc_dat_i[i][ADC_RAW_W-1],
                    ~adc_dat_i[i][ADC_RAW_W-2:ADC_RAW_W-SMP_W]};
      // Generator sample replaces the ADC when looped back
      smp_sel[i] = loop_i[i] ? gen_dat_i[i] : adc_cnv[i];
    end
  end

  // Single register stage, same latency for both paths
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_smp_o <= '0;
    end else begin
      adc_smp_o <= smp_sel;
    end
  end

endmodule

// File: logic/dac_backend.sv
// DAC back end
// Signed generator samples to DAC code
// Two channels interleaved on one bus with a select line

`timescale 1ns/1ps

module dac_backend (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  input  rp_pkg::smp_t     [rp_pkg::RP_CHN-1:0] gen_dat_i,
  output rp_pkg::dac_code_t                     dac_dat_o,
  output logic                                  dac_sel_o
);

  import rp_pkg::*;

  // DAC codes of the last sampled generator words
  dac_code_t [RP_CHN-1:0] code_q;
  // Channel select, high for channel 0
  logic                   sel_q;

  ////////////////////////////////////////
  // Code registers and select flop
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      code_q <= '0;
      sel_q  <= 1'b1;
    end else begin
      // Alternates every cycle
      sel_q <= ~sel_q;
      for (int i = 0; i < RP_CHN; i++) begin
        // Offset binary with negative slope, sign bit kept
        code_q[i] <= {gen_dat_i[i][SMP_W-1], ~gen_dat_i[i][SMP_W-2:0]};
      end
    end
  end

  // Shared DAC bus
  // Channel 0 on the high phase, channel 1 on the low phase
  assign dac_dat_o = sel_q ? code_q[0] : code_q[1];
  assign dac_sel_o = sel_q;

endmodule

// File: logic/pdm_dac.sv
// Four-channel pulse-density modulator
// Modulo accumulator per channel, carry drives the output bit

`timescale 1ns/1ps

module pdm_dac (
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  input  rp_pkg::pdm_lvl_t [rp_pkg::PDM_CHN-1:0]    lvl_i,
  output logic             [rp_pkg::PDM_CHN-1:0]    pdm_o
);

  import rp_pkg::*;

  // Accumulator state, always below the range
  logic [PDM_CHN-1:0][PDM_W-1:0] acc_q;
  // One extra bit for the sum
  logic [PDM_CHN-1:0][PDM_W:0]   acc_sum;
  logic [PDM_CHN-1:0][PDM_W-1:0] acc_nxt;
  logic [PDM_CHN-1:0]            carry;

  ////////////////////////////////////////
  // Accumulate and wrap
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < PDM_CHN; i++) begin
      acc_sum[i] = {1'b0, acc_q[i]} + {1'b0, lvl_i[i]};
      // Pulse whenever the sum passes the range
      carry[i]   = acc_sum[i] >= (PDM_W+1)'(PDM_RNG);
      // Largest wrapped value is 254, fits the state width
      acc_nxt[i] = carry[i] ? PDM_W'(acc_sum[i] - (PDM_W+1)'(PDM_RNG))
                            : acc_sum[i][PDM_W-1:0];
    end
  end

  // Level 255 sets the carry every cycle
  // Level 0 never does
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      acc_q <= '0;
      pdm_o <= '0;
    end else begin
      acc_q <= acc_nxt;
      pdm_o <= carry;
    end
  end

endmodule

// File: logic/rp_top.sv
// Top level of the analog signal path
// Pins to register bus, ADC front end, DAC back end and PDM outputs

`timescale 1ns/1ps

module rp_top (
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  // ADC and generator samples
  input  rp_pkg::adc_raw_t  [rp_pkg::RP_CHN-1:0]   adc_dat_i,
  input  rp_pkg::smp_t      [rp_pkg::RP_CHN-1:0]   gen_dat_i,
  // Register access
  input  logic                                     reg_wen_i,
  input  logic                                     reg_ren_i,
  input  logic              [rp_pkg::REG_AW-1:0]   reg_addr_i,
  input  logic              [rp_pkg::REG_DW-1:0]   reg_wdata_i,
  // Outputs
  output rp_pkg::smp_t      [rp_pkg::RP_CHN-1:0]   adc_smp_o,
  output rp_pkg::dac_code_t                        dac_dat_o,
  output logic                                     dac_sel_o,
  output logic              [rp_pkg::PDM_CHN-1:0]  pdm_o,
  output logic              [rp_pkg::REG_DW-1:0]   reg_rdata_o
);

  import rp_pkg::*;

  // Configuration from the register block
  logic     [RP_CHN-1:0]  loop;
  pdm_lvl_t [PDM_CHN-1:0] pdm_lvl;

  ////////////////////////////////////////
  // Register bus
  ////////////////////////////////////////

  reg_bus_if bus ();

  // Master side driven straight from the pins
  assign bus.wen     = reg_wen_i;
  assign bus.ren     = reg_ren_i;
  assign bus.addr    = reg_addr_i;
  assign bus.wdata   = reg_wdata_i;
  assign reg_rdata_o = bus.rdata;

  rp_ctl_regs i_ctl_regs (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .bus       (bus.slave),
    .loop_o    (loop),
    .pdm_lvl_o (pdm_lvl)
  );

  ////////////////////////////////////////
  // Analog paths
  ////////////////////////////////////////

  // Generator samples feed both the DAC and the loopback
  adc_frontend i_adc_frontend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .gen_dat_i (gen_dat_i),
    .loop_i    (loop),
    .adc_smp_o (adc_smp_o)
  );

  dac_backend i_dac_backend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_dat_i (gen_dat_i),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o)
  );

  // Slow analog outputs
  pdm_dac i_pdm_dac (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .lvl_i   (pdm_lvl),
    .pdm_o   (pdm_o)
  );

endmodule

// File: bench/rp_assert.sv
// Concurrent assertions on the top-level pins
// Bound into the rp_top instance

`timescale 1ns/1ps

module rp_assert (
  input logic                        adc_clk,
  input logic                        top_rst,
  input logic                        dac_sel_i,
  input logic [rp_pkg::PDM_CHN-1:0]  pdm_i,
  input logic                        reg_ren_i,
  input logic [rp_pkg::REG_DW-1:0]   rdata_i
);

  // Failure count for the closing summary
  int fail_cnt = 0;

  // Select line alternates once out of reset
  sel_toggle: assert property (@(posedge adc_clk) disable iff (top_rst)
    !$past(top_rst) |-> dac_sel_i != $past(dac_sel_i)) else begin
    fail_cnt++;
    $error("dac_sel_o did not toggle");
  end

  // Reset state of the DAC select and PDM pins
  rst_state: assert property (@(posedge adc_clk) top_rst |-> dac_sel_i && pdm_i == '0)
    else begin
    fail_cnt++;
    $error("dac_sel_o or pdm_o wrong during reset");
  end

  // Read data moves only after a read strobe
  rdata_hold: assert property (@(posedge adc_clk) disable iff (top_rst)
    !$past(reg_ren_i) |-> $stable(rdata_i)) else begin
    fail_cnt++;
    $error("reg_rdata_o changed without a read");
  end

endmodule

bind rp_top rp_assert i_rp_assert (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .dac_sel_i (dac_sel_o),
  .pdm_i     (pdm_o),
  .reg_ren_i (reg_ren_i),
  .rdata_i   (reg_rdata_o)
);

// File: bench/rp_checker.sv
// Reference model and comparison for all DUT outputs
// Register shadow, ADC and DAC data path checks, PDM window counts

`timescale 1ns/1ps

module rp_checker (
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  input  rp_pkg::adc_raw_t  [rp_pkg::RP_CHN-1:0]  adc_dat_i,
  input  rp_pkg::smp_t      [rp_pkg::RP_CHN-1:0]  gen_dat_i,
  input  logic                                    reg_wen_i,
  input  logic                                    reg_ren_i,
  input  logic              [rp_pkg::REG_AW-1:0]  reg_addr_i,
  input  logic              [rp_pkg::REG_DW-1:0]  reg_wdata_i,
  input  rp_pkg::smp_t      [rp_pkg::RP_CHN-1:0]  adc_smp_i,
  input  rp_pkg::dac_code_t                       dac_dat_i,
  input  logic                                    dac_sel_i,
  input  logic              [rp_pkg::PDM_CHN-1:0] pdm_i,
  input  logic              [rp_pkg::REG_DW-1:0]  reg_rdata_i,
  input  logic                                    win_start_i,
  output logic                                    win_done_o,
  output int                                      adc_err_o,
  output int                                      dac_err_o,
  output int                                      reg_err_o,
  output int                                      pdm_err_o
);

  import rp_pkg::*;

  // Register shadow built from observed writes
  logic     [RP_CHN-1:0]  loop_m;
  pdm_lvl_t [PDM_CHN-1:0] lvl_m;
  logic     [REG_DW-1:0]  rd_exp;
  logic                   sel_m;
  // Inputs seen at the previous edge
  adc_raw_t [RP_CHN-1:0]  adc_prev;
  smp_t     [RP_CHN-1:0]  gen_prev;
  logic     [RP_CHN-1:0]  loop_prev;
  logic                   prev_vld;
  // PDM window state
  logic                   win_act;
  int                     win_left;
  int                     win_hi [PDM_CHN];
  pdm_lvl_t [PDM_CHN-1:0] win_lvl;

  ////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////

  // Upper 14 bits, sign kept, magnitude bits flipped
  function automatic smp_t adc_conv_ref(adc_raw_t raw);
    logic [SMP_W-1:0] top_bits;
    top_bits = raw[ADC_RAW_W-1:ADC_RAW_W-SMP_W];
    return smp_t'(top_bits ^ {1'b0, {(SMP_W-1){1'b1}}});
  endfunction

  function automatic dac_code_t dac_code_ref(smp_t smp);
    return dac_code_t'(smp) ^ {1'b0, {(SMP_W-1){1'b1}}};
  endfunction

  function automatic logic [REG_DW-1:0] reg_read_ref(logic [REG_AW-1:0] addr);
    logic [REG_DW-1:0] val;
    val = '0;
    case (addr)
      REG_ID:   val = RP_ID_VAL;
      REG_LOOP: val = REG_DW'(loop_m);
      default: begin
        if (addr >= REG_PDM0 && addr < REG_PDM0 + PDM_CHN) begin
          val = REG_DW'(lvl_m[addr - REG_PDM0]);
        end
      end
    endcase
    return val;
  endfunction

  // High bits expected in a window of len cycles
  function automatic int pdm_count_ref(pdm_lvl_t lvl, int len);
    return (int'(lvl) * len) / PDM_RNG;
  endfunction

  task automatic check_val(input string sig, input logic [REG_DW-1:0] act,
                           input logic [REG_DW-1:0] exp, inout int cnt);
    if (act !== exp) begin
      cnt++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, sig, exp, act);
    end
  endtask

  initial begin
    adc_err_o  = 0;
    dac_err_o  = 0;
    reg_err_o  = 0;
    pdm_err_o  = 0;
    win_done_o = 1'b0;
  end

  ////////////////////////////////////////
  // Compare and track
  ////////////////////////////////////////

  always @(posedge adc_clk) begin
    if (top_rst) begin
      // Reset values on every output
      check_val("adc_smp_o", REG_DW'(adc_smp_i), '0, adc_err_o);
      check_val("dac_dat_o", REG_DW'(dac_dat_i), '0, dac_err_o);
      check_val("dac_sel_o", REG_DW'(dac_sel_i), 1, dac_err_o);
      check_val("pdm_o", REG_DW'(pdm_i), '0, pdm_err_o);
      check_val("reg_rdata_o", reg_rdata_i, '0, reg_err_o);
      loop_m     = '0;
      lvl_m      = '0;
      rd_exp     = '0;
      sel_m      = 1'b1;
      prev_vld   = 1'b0;
      win_act    = 1'b0;
      win_done_o = 1'b0;
    end else begin
      // Data path against last edge's inputs
      if (prev_vld) begin
        for (int i = 0; i < RP_CHN; i++) begin
          check_val($sformatf("adc_smp_o[%0d]", i), REG_DW'(adc_smp_i[i]),
                    REG_DW'(loop_prev[i] ? gen_prev[i] : adc_conv_ref(adc_prev[i])),
                    adc_err_o);
        end
        check_val("dac_dat_o", REG_DW'(dac_dat_i),
                  REG_DW'(dac_code_ref(sel_m ? gen_prev[0] : gen_prev[1])), dac_err_o);
      end
      check_val("dac_sel_o", REG_DW'(dac_sel_i), REG_DW'(sel_m), dac_err_o);
      // Read data holds between reads
      check_val("reg_rdata_o", reg_rdata_i, rd_exp, reg_err_o);
      if (win_start_i && !win_act) begin
        win_act    = 1'b1;
        win_left   = PDM_RNG;
        win_lvl    = lvl_m;
        win_done_o = 1'b0;
        foreach (win_hi[i]) win_hi[i] = 0;
      end
      if (win_act) begin
        for (int i = 0; i < PDM_CHN; i++) begin
          win_hi[i] += pdm_i[i];
        end
        win_left--;
        if (win_left == 0) begin
          for (int i = 0; i < PDM_CHN; i++) begin
            check_val($sformatf("pdm_o[%0d] high count", i), REG_DW'(win_hi[i]),
                      REG_DW'(pdm_count_ref(win_lvl[i], PDM_RNG)), pdm_err_o);
          end
          win_act    = 1'b0;
          win_done_o = 1'b1;
        end
      end
      // Model update for this edge, reads see old contents
      sel_m     = ~sel_m;
      adc_prev  = adc_dat_i;
      gen_prev  = gen_dat_i;
      loop_prev = loop_m;
      prev_vld  = 1'b1;
      if (reg_ren_i) begin
        rd_exp = reg_read_ref(reg_addr_i);
      end
      if (reg_wen_i && reg_addr_i == REG_LOOP) begin
        loop_m = reg_wdata_i[RP_CHN-1:0];
      end
      if (reg_wen_i && reg_addr_i >= REG_PDM0 && reg_addr_i < REG_PDM0 + PDM_CHN) begin
        lvl_m[reg_addr_i - REG_PDM0] = reg_wdata_i[PDM_W-1:0];
      end
    end
  end

endmodule

// File: bench/rp_tb.sv
// Testbench top with clock, reset and random sample stimulus
// Register accesses for loopback and PDM levels, closing summary

`timescale 1ns/1ps

module rp_tb;

  import rp_pkg::*;

  logic                   adc_clk;
  logic                   top_rst;
  adc_raw_t [RP_CHN-1:0]  adc_dat;
  smp_t     [RP_CHN-1:0]  gen_dat;
  logic                   reg_wen;
  logic                   reg_ren;
  logic     [REG_AW-1:0]  reg_addr;
  logic     [REG_DW-1:0]  reg_wdata;
  smp_t     [RP_CHN-1:0]  adc_smp;
  dac_code_t              dac_dat;
  logic                   dac_sel;
  logic     [PDM_CHN-1:0] pdm;
  logic     [REG_DW-1:0]  reg_rdata;
  logic                   win_start;
  logic                   win_done;
  int                     adc_err;
  int                     dac_err;
  int                     reg_err;
  int                     pdm_err;
  int                     tmo_cnt;
  integer                 seed;
  logic     [31:0]        rnd;

  // 40 ns period
  always #20 adc_clk = ~adc_clk;

  rp_top i_rp_top (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat),
    .gen_dat_i   (gen_dat),
    .reg_wen_i   (reg_wen),
    .reg_ren_i   (reg_ren),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .adc_smp_o   (adc_smp),
    .dac_dat_o   (dac_dat),
    .dac_sel_o   (dac_sel),
    .pdm_o       (pdm),
    .reg_rdata_o (reg_rdata)
  );

  rp_checker i_checker (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat),
    .gen_dat_i   (gen_dat),
    .reg_wen_i   (reg_wen),
    .reg_ren_i   (reg_ren),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .adc_smp_i   (adc_smp),
    .dac_dat_i   (dac_dat),
    .dac_sel_i   (dac_sel),
    .pdm_i       (pdm),
    .reg_rdata_i (reg_rdata),
    .win_start_i (win_start),
    .win_done_o  (win_done),
    .adc_err_o   (adc_err),
    .dac_err_o   (dac_err),
    .reg_err_o   (reg_err),
    .pdm_err_o   (pdm_err)
  );

  // Fresh ADC and generator words every cycle
  always @(negedge adc_clk) begin
    for (int i = 0; i < RP_CHN; i++) begin
      rnd        = $random(seed);
      adc_dat[i] = rnd[ADC_RAW_W-1:0];
      gen_dat[i] = rnd[31 -: SMP_W];
    end
  end

  ////////////////////////////////////////
  // Register and PDM helpers
  ////////////////////////////////////////

  task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
    @(negedge adc_clk);
    reg_wen   = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge adc_clk);
    reg_wen   = 1'b0;
  endtask

  task automatic reg_read(input logic [REG_AW-1:0] addr);
    @(negedge adc_clk);
    reg_ren  = 1'b1;
    reg_addr = addr;
    @(negedge adc_clk);
    reg_ren  = 1'b0;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(negedge adc_clk);
  endtask

  // Write four levels, read them back, then count one window
  task automatic measure_pdm_levels(input pdm_lvl_t [PDM_CHN-1:0] lvls);
    int waited;
    waited = 0;
    for (int i = 0; i < PDM_CHN; i++) begin
      reg_write(REG_PDM0 + REG_AW'(i), REG_DW'(lvls[i]));
    end
    for (int i = 0; i < PDM_CHN; i++) begin
      reg_read(REG_PDM0 + REG_AW'(i));
    end
    run_cycles(3);
    win_start = 1'b1;
    @(negedge adc_clk);
    win_start = 1'b0;
    while (!win_done && waited < PDM_RNG + 64) begin
      @(negedge adc_clk);
      waited++;
    end
    if (!win_done) begin
      tmo_cnt++;
      $display("timeout: PDM window did not finish within %0d cycles", waited);
    end
  endtask

  initial begin
    int total;
    seed      = 32'h54ee;
    adc_clk   = 1'b0;
    top_rst   = 1'b1;
    adc_dat   = '0;
    gen_dat   = '0;
    reg_wen   = 1'b0;
    reg_ren   = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    win_start = 1'b0;
    tmo_cnt   = 0;
    repeat (2) @(negedge adc_clk);
    top_rst = 1'b0;
    // Identification word and unmapped addresses
    reg_read(REG_ID);
    reg_read(4'd3);
    reg_write(4'd3, 32'hffff_ffff);
    reg_read(4'd3);
    reg_read(4'hf);
    // Plain ADC path
    run_cycles(20);
    // Loopback one channel at a time, then both
    reg_write(REG_LOOP, 32'd1);
    run_cycles(16);
    reg_read(REG_LOOP);
    reg_write(REG_LOOP, 32'd2);
    run_cycles(16);
    reg_read(REG_LOOP);
    reg_write(REG_LOOP, 32'd3);
    run_cycles(8);
    reg_write(REG_LOOP, 32'd0);
    run_cycles(8);
    // PDM densities including both ends of the range
    measure_pdm_levels({8'd128, 8'd1, 8'd255, 8'd0});
    measure_pdm_levels({8'd0, 8'd255, 8'd37, 8'd200});
    run_cycles(4);
    total = adc_err + dac_err + reg_err + pdm_err + tmo_cnt
          + i_rp_top.i_rp_assert.fail_cnt;
    $display("errors: adc %0d, dac %0d, reg %0d, pdm %0d, timeout %0d, assert %0d",
             adc_err, dac_err, reg_err, pdm_err, tmo_cnt, i_rp_top.i_rp_assert.fail_cnt);
    if (total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim.f
logic/rp_pkg.sv
logic/reg_bus_if.sv
logic/rp_ctl_regs.sv
logic/adc_frontend.sv
logic/dac_backend.sv
logic/pdm_dac.sv
logic/rp_top.sv
bench/rp_assert.sv
bench/rp_checker.sv
bench/rp_tb.sv

// File: Bender.yml
package:
  name: rp_signal_path

sources:
  - logic/rp_pkg.sv
  - logic/reg_bus_if.sv
  - logic/rp_ctl_regs.sv
  - logic/adc_frontend.sv
  - logic/dac_backend.sv
  - logic/pdm_dac.sv
  - logic/rp_top.sv
  - target: simulation
    files:
      - bench/rp_assert.sv
      - bench/rp_checker.sv
      - bench/rp_tb.sv
